// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = RenameUnitTb
FILELIST  = RenameUnit.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Testbench failed" $(LOG); then exit 1; fi
	@grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== RenameUnit.f ====
rtl/regPkg.sv
rtl/robPkg.sv
rtl/Freelist.sv
rtl/RenameMapTable.sv
rtl/RenameBypass.sv
rtl/RenameUnit.sv
tests/RenameUnit_assert.sv
tests/RenameUnitTb.sv

// ==== rtl/Freelist.sv ====
`timescale 1ns/1ps
`default_nettype none

module Freelist #(
    parameter int FetchWidth = 4,
    parameter int CommitWidth = 4,
    parameter int PregCount = 96,
    localparam int FreeWidth = $clog2(PregCount - 31)
) (
    input  logic clk,
    input  logic reset,
    input  logic [$clog2(FetchWidth+1)-1:0] allocNum,
    input  logic allocEn,
    output regPkg::preg_t [FetchWidth-1:0] allocPreg,
    output logic [FreeWidth-1:0] freeCount,
    input  robPkg::commitEntry_t [CommitWidth-1:0] commitGroup,
    input  logic walkActive,
    input  robPkg::walkEntry_t [CommitWidth-1:0] walkGroup
);
    localparam int Depth = PregCount - 32;
    localparam int PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int CntWidth = $clog2(CommitWidth + 1);

    typedef logic [PtrWidth-1:0] ptr_t;

    regPkg::preg_t entries [Depth];
    ptr_t head;   // next slot to receive a released register
    ptr_t tail;   // next register to hand out
    logic [CntWidth-1:0] releaseNum;
    logic [CntWidth-1:0] walkNum;
    logic [CommitWidth-1:0] releaseEn;
    ptr_t releaseIdx [CommitWidth];
    logic [$clog2(FetchWidth+1)-1:0] allocTake;

    // pointer arithmetic modulo the depth, which need not be a power of two
    function automatic ptr_t wrapAdd(ptr_t base, int offset);
        int sum;
        sum = int'(base) + offset;
        if (sum >= Depth) begin
            sum = sum - Depth;
        end else if (sum < 0) begin
            sum = sum + Depth;
        end
        return ptr_t'(sum);
    endfunction

    always_comb begin
        for (int i = 0; i < FetchWidth; i++) begin
            allocPreg[i] = entries[wrapAdd(tail, i)];
        end
    end

    // released registers pack densely behind the head in slot order
    always_comb begin
        releaseNum = '0;
        for (int i = 0; i < CommitWidth; i++) begin
            releaseEn[i] = commitGroup[i].valid & commitGroup[i].rdValid;
            releaseIdx[i] = wrapAdd(head, int'(releaseNum));
            releaseNum = releaseNum + CntWidth'(releaseEn[i]);
        end
    end

    always_comb begin
        walkNum = '0;
        for (int i = 0; i < CommitWidth; i++) begin
            walkNum = walkNum + CntWidth'(walkActive & walkGroup[i].valid);
        end
    end

    assign allocTake = allocEn ? allocNum : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < Depth; i++) begin
                entries[i] <= regPkg::preg_t'(i + 32);
            end
            head <= '0;   // depth wraps to zero, the list starts full
            tail <= '0;
            freeCount <= FreeWidth'(Depth);
        end else begin
            for (int i = 0; i < CommitWidth; i++) begin
                if (releaseEn[i]) begin
                    entries[releaseIdx[i]] <= commitGroup[i].oldPrd;
                end
            end
            head <= wrapAdd(head, int'(releaseNum));
            // walked registers are still in place just behind the tail
            if (walkActive) begin
                tail <= wrapAdd(tail, -int'(walkNum));
            end else begin
                tail <= wrapAdd(tail, int'(allocTake));
            end
            freeCount <= freeCount + FreeWidth'(releaseNum) + FreeWidth'(walkNum)
                - FreeWidth'(allocTake);
        end
    end

endmodule

`default_nettype wire

// ==== rtl/RenameBypass.sv ====
`timescale 1ns/1ps
`default_nettype none

module RenameBypass #(
    parameter int FetchWidth = 4
) (
    input  regPkg::renameReq_t [FetchWidth-1:0] req,
    input  regPkg::preg_t [FetchWidth-1:0][1:0] tableSrc,
    input  regPkg::preg_t [FetchWidth-1:0] tableOldDst,
    input  regPkg::preg_t [FetchWidth-1:0] allocPreg,
    output regPkg::renameRsp_t [FetchWidth-1:0] rsp,
    output logic [$clog2(FetchWidth+1)-1:0] allocNum,
    output logic [FetchWidth-1:0] writeEn,
    output regPkg::preg_t [FetchWidth-1:0] writePreg
);
    localparam int NumWidth = $clog2(FetchWidth + 1);

    // the k-th writing slot takes the k-th register offered by the free list
    always_comb begin
        allocNum = '0;
        for (int i = 0; i < FetchWidth; i++) begin
            writeEn[i] = req[i].valid & req[i].rdValid;
            writePreg[i] = allocPreg[allocNum];
            allocNum = allocNum + NumWidth'(writeEn[i]);
        end
    end

    always_comb begin
        for (int i = 0; i < FetchWidth; i++) begin
            rsp[i].prs1 = tableSrc[i][0];
            rsp[i].prs2 = tableSrc[i][1];
            rsp[i].oldPrd = tableOldDst[i];
            rsp[i].prd = writeEn[i] ? writePreg[i] : '0;
            // scanning upward leaves the nearest earlier writer in place
            for (int j = 0; j < i; j++) begin
                if (writeEn[j] && req[j].rd == req[i].rs1) begin
                    rsp[i].prs1 = writePreg[j];
                end
                if (writeEn[j] && req[j].rd == req[i].rs2) begin
                    rsp[i].prs2 = writePreg[j];
                end
                if (writeEn[j] && req[j].rd == req[i].rd) begin
                    rsp[i].oldPrd = writePreg[j];   // freed when slot i commits
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/RenameMapTable.sv ====
`timescale 1ns/1ps
`default_nettype none

module RenameMapTable #(
    parameter int FetchWidth = 4,
    parameter int CommitWidth = 4
) (
    input  logic clk,
    input  logic reset,
    input  regPkg::archReg_t [FetchWidth-1:0][1:0] srcArch,
    output regPkg::preg_t [FetchWidth-1:0][1:0] srcPreg,
    input  regPkg::archReg_t [FetchWidth-1:0] dstArch,
    output regPkg::preg_t [FetchWidth-1:0] dstPregOld,
    input  logic [FetchWidth-1:0] writeEn,
    input  regPkg::preg_t [FetchWidth-1:0] writePreg,
    input  logic walkActive,
    input  robPkg::walkEntry_t [CommitWidth-1:0] walkGroup
);
    localparam int ArchCount = 1 << regPkg::ArchRegWidth;

    regPkg::preg_t map [ArchCount];   // speculative mapping, includes all renamed groups

    // reads see the table as it was before this group
    always_comb begin
        for (int i = 0; i < FetchWidth; i++) begin
            srcPreg[i][0] = map[srcArch[i][0]];
            srcPreg[i][1] = map[srcArch[i][1]];
            dstPregOld[i] = map[dstArch[i]];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < ArchCount; i++) begin
                map[i] <= regPkg::preg_t'(i);
            end
        end else if (walkActive) begin
            // entries come youngest first, so the last write is the oldest one
            for (int i = 0; i < CommitWidth; i++) begin
                if (walkGroup[i].valid) begin
                    map[walkGroup[i].rd] <= walkGroup[i].oldPrd;
                end
            end
        end else begin
            for (int i = 0; i < FetchWidth; i++) begin
                if (writeEn[i]) begin
                    map[dstArch[i]] <= writePreg[i];   // a younger slot overrides an older one
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/RenameUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module RenameUnit #(
    parameter int FetchWidth = 4,
    parameter int CommitWidth = 4,
    parameter int PregCount = 96
) (
    input  logic clk,
    input  logic reset,
    input  regPkg::renameReq_t [FetchWidth-1:0] reqGroup,
    output logic reqReady,
    output regPkg::renameRsp_t [FetchWidth-1:0] rspGroup,
    input  robPkg::backendStall_t backendStall,
    input  robPkg::commitEntry_t [CommitWidth-1:0] commitGroup,
    input  logic walkActive,
    input  robPkg::walkEntry_t [CommitWidth-1:0] walkGroup,
    output logic [$clog2(PregCount-31)-1:0] freeCount
);
    regPkg::preg_t [FetchWidth-1:0] allocPreg;
    logic [$clog2(FetchWidth+1)-1:0] allocNum;
    logic [FetchWidth-1:0] slotWriteEn;
    logic [FetchWidth-1:0] tableWriteEn;
    regPkg::preg_t [FetchWidth-1:0] writePreg;
    regPkg::archReg_t [FetchWidth-1:0][1:0] srcArch;
    regPkg::preg_t [FetchWidth-1:0][1:0] srcPreg;
    regPkg::archReg_t [FetchWidth-1:0] dstArch;
    regPkg::preg_t [FetchWidth-1:0] dstPregOld;
    logic anyValid;
    logic accept;

    always_comb begin
        anyValid = 1'b0;
        for (int i = 0; i < FetchWidth; i++) begin
            srcArch[i][0] = reqGroup[i].rs1;
            srcArch[i][1] = reqGroup[i].rs2;
            dstArch[i] = reqGroup[i].rd;
            anyValid = anyValid | reqGroup[i].valid;
        end
    end

    // the group goes through only when every writer can get a register right now
    assign reqReady = !reset && !walkActive && !(|backendStall) && freeCount >= allocNum;
    assign accept = anyValid & reqReady;
    assign tableWriteEn = slotWriteEn & {FetchWidth{accept}};

    Freelist #(
        .FetchWidth(FetchWidth),
        .CommitWidth(CommitWidth),
        .PregCount(PregCount)
    ) freeList (
        .clk(clk),
        .reset(reset),
        .allocNum(allocNum),
        .allocEn(accept),
        .allocPreg(allocPreg),
        .freeCount(freeCount),
        .commitGroup(commitGroup),
        .walkActive(walkActive),
        .walkGroup(walkGroup)
    );

    RenameMapTable #(
        .FetchWidth(FetchWidth),
        .CommitWidth(CommitWidth)
    ) mapTable (
        .clk(clk),
        .reset(reset),
        .srcArch(srcArch),
        .srcPreg(srcPreg),
        .dstArch(dstArch),
        .dstPregOld(dstPregOld),
        .writeEn(tableWriteEn),
        .writePreg(writePreg),
        .walkActive(walkActive),
        .walkGroup(walkGroup)
    );

    RenameBypass #(
        .FetchWidth(FetchWidth)
    ) bypass (
        .req(reqGroup),
        .tableSrc(srcPreg),
        .tableOldDst(dstPregOld),
        .allocPreg(allocPreg),
        .rsp(rspGroup),
        .allocNum(allocNum),
        .writeEn(slotWriteEn),
        .writePreg(writePreg)
    );

endmodule

`default_nettype wire

// ==== rtl/regPkg.sv ====
`default_nettype none

// architectural and physical register types shared by the rename stage
package regPkg;

    localparam int ArchRegWidth = 5;  // 32 architectural registers
    localparam int PregWidth = 7;     // room for up to 128 physical registers

    typedef logic [ArchRegWidth-1:0] archReg_t;
    typedef logic [PregWidth-1:0] preg_t;

    // one instruction slot as it arrives from decode
    typedef struct packed {
        logic valid;
        logic rdValid;    // instruction writes rd
        archReg_t rd;
        archReg_t rs1;
        archReg_t rs2;
    } renameReq_t;

    // renamed view of the same slot
    typedef struct packed {
        preg_t prs1;
        preg_t prs2;
        preg_t prd;       // zero for slots that write no register
        preg_t oldPrd;    // mapping of rd before this instruction, freed at commit
    } renameRsp_t;

endpackage

`default_nettype wire

// ==== rtl/robPkg.sv ====
`default_nettype none

// buses coming back from the reorder buffer and the rest of the back end
package robPkg;

    // one retiring instruction
    typedef struct packed {
        logic valid;
        logic rdValid;
        regPkg::preg_t oldPrd;   // goes back to the free list
    } commitEntry_t;

    // one instruction undone by a misprediction walk, youngest first in the group
    typedef struct packed {
        logic valid;
        regPkg::archReg_t rd;
        regPkg::preg_t oldPrd;   // mapping to put back into the table
    } walkEntry_t;

    typedef struct packed {
        logic robFull;
        logic dispatchFull;
        logic redirect;
    } backendStall_t;

endpackage

`default_nettype wire

// ==== tests/RenameUnitTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module RenameUnitTb;
    localparam int FW = 4;
    localparam int CW = 4;
    localparam int PC = 96;
    localparam int TestCycles = 4000;

    typedef struct packed {
        regPkg::archReg_t rd;
        regPkg::preg_t prd;
        regPkg::preg_t oldPrd;
    } flight_t;

    logic clk;
    logic reset;
    regPkg::renameReq_t [FW-1:0] reqGroup;
    logic reqReady;
    regPkg::renameRsp_t [FW-1:0] rspGroup;
    robPkg::backendStall_t backendStall;
    robPkg::commitEntry_t [CW-1:0] commitGroup;
    logic walkActive;
    robPkg::walkEntry_t [CW-1:0] walkGroup;
    logic [$clog2(PC-31)-1:0] freeCount;

    regPkg::preg_t refMap [32];
    regPkg::preg_t freeQ [$];
    flight_t inflight [$];   // renamed writers, oldest first
    logic [15:0] lfsr = 16'd25075;
    logic lastAccept = 1'b0;
    int errors = 0;
    int checks = 0;

    RenameUnit #(.FetchWidth(FW), .CommitWidth(CW), .PregCount(PC)) i_dut (.*);

    bind RenameUnit RenameUnitAssert #(.CommitWidth(CommitWidth), .PregCount(PregCount)) renameAsserts (
        .clk(clk), .reset(reset), .freeCount(freeCount),
        .walkActive(walkActive), .accept(accept), .commitGroup(commitGroup));

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic int randBits(int n);
        int value;
        logic lsb;
        value = 0;
        for (int i = 0; i < n; i++) begin
            lsb = lfsr[0];
            lfsr = lfsr >> 1;
            if (lsb) lfsr = lfsr ^ 16'hB400;
            value = (value << 1) | int'(lsb);
        end
        return value;
    endfunction

    // expected rename of a group against the model map and free queue
    function automatic void refRename(input regPkg::renameReq_t [FW-1:0] g,
            output regPkg::renameRsp_t [FW-1:0] rsp, output int writers);
        logic [FW-1:0] wr;
        writers = 0;
        for (int i = 0; i < FW; i++) begin
            wr[i] = g[i].valid & g[i].rdValid;
            rsp[i].prs1 = refMap[g[i].rs1];
            rsp[i].prs2 = refMap[g[i].rs2];
            rsp[i].oldPrd = refMap[g[i].rd];
            rsp[i].prd = '0;
            for (int j = 0; j < i; j++) begin
                if (wr[j] && g[j].rd == g[i].rs1) rsp[i].prs1 = rsp[j].prd;
                if (wr[j] && g[j].rd == g[i].rs2) rsp[i].prs2 = rsp[j].prd;
                if (wr[j] && g[j].rd == g[i].rd) rsp[i].oldPrd = rsp[j].prd;
            end
            if (wr[i]) begin
                if (writers < freeQ.size()) rsp[i].prd = freeQ[writers];
                writers++;
            end
        end
    endfunction

    task automatic checkValue(string name, int got, int exp);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("Error at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    always @(negedge clk) begin : compareProc
        regPkg::renameRsp_t [FW-1:0] expRsp;
        int writers;
        logic expReady;
        logic anyValid;
        flight_t rec;
        if (reset) begin
            checkValue("reqReady", int'(reqReady), 0);
            lastAccept = 1'b0;
        end else begin
            refRename(reqGroup, expRsp, writers);
            anyValid = 1'b0;
            for (int i = 0; i < FW; i++) anyValid = anyValid | reqGroup[i].valid;
            expReady = !walkActive && backendStall == '0 && freeQ.size() >= writers;
            checkValue("freeCount", int'(freeCount), freeQ.size());
            checkValue("reqReady", int'(reqReady), int'(expReady));
            for (int i = 0; i < FW; i++) begin
                if (reqGroup[i].valid && freeQ.size() >= writers) begin
                    checkValue($sformatf("rspGroup[%0d].prs1", i), rspGroup[i].prs1,
                        expRsp[i].prs1);
                    checkValue($sformatf("rspGroup[%0d].prs2", i), rspGroup[i].prs2,
                        expRsp[i].prs2);
                    checkValue($sformatf("rspGroup[%0d].prd", i), rspGroup[i].prd,
                        expRsp[i].prd);
                    checkValue($sformatf("rspGroup[%0d].oldPrd", i), rspGroup[i].oldPrd,
                        expRsp[i].oldPrd);
                end
            end
            lastAccept = anyValid && expReady;
            // allocation takes from the front before releases land at the back
            for (int i = 0; i < FW; i++) begin
                if (lastAccept && reqGroup[i].valid && reqGroup[i].rdValid) begin
                    rec.rd = reqGroup[i].rd;
                    rec.prd = expRsp[i].prd;
                    rec.oldPrd = expRsp[i].oldPrd;
                    refMap[rec.rd] = rec.prd;
                    inflight.push_back(rec);
                    void'(freeQ.pop_front());
                end
            end
            for (int i = 0; i < CW; i++) begin
                if (commitGroup[i].valid && commitGroup[i].rdValid) begin
                    freeQ.push_back(commitGroup[i].oldPrd);
                    void'(inflight.pop_front());
                end
                if (walkActive && walkGroup[i].valid) begin
                    refMap[walkGroup[i].rd] = walkGroup[i].oldPrd;
                    rec = inflight.pop_back();
                    freeQ.push_front(rec.prd);
                end
            end
        end
    end

    task automatic stepCycle();
        @(posedge clk);
        #2;
        commitGroup = '0;
        walkActive = 1'b0;
        walkGroup = '0;
        backendStall = '0;
    endtask

    task automatic driveCommit(int n);
        int k;
        k = 0;
        for (int i = 0; i < CW; i++) begin
            if (k < n && k < inflight.size()) begin
                commitGroup[i].valid = 1'b1;
                commitGroup[i].rdValid = randBits(2) != 0;   // some retire without rd
                commitGroup[i].oldPrd = inflight[k].oldPrd;
                if (commitGroup[i].rdValid) k++;
            end
        end
    endtask

    task automatic driveWalk(int n);
        int size;
        size = inflight.size();
        walkActive = 1'b1;
        for (int i = 0; i < n && i < size; i++) begin
            walkGroup[i].valid = 1'b1;
            walkGroup[i].rd = inflight[size-1-i].rd;
            walkGroup[i].oldPrd = inflight[size-1-i].oldPrd;
        end
    endtask

    function automatic regPkg::renameReq_t [FW-1:0] randomGroup(logic allWriters);
        regPkg::renameReq_t [FW-1:0] g;
        int n;
        n = allWriters ? FW : randBits(2) + 1;
        g = '0;
        for (int i = 0; i < n; i++) begin
            g[i].valid = 1'b1;
            g[i].rdValid = allWriters || randBits(2) != 0;
            g[i].rd = regPkg::archReg_t'(randBits(5));
            g[i].rs1 = regPkg::archReg_t'(randBits(5));
            g[i].rs2 = regPkg::archReg_t'(randBits(5));
        end
        return g;
    endfunction

    // holds the group until the DUT takes it
    task automatic sendGroup(regPkg::renameReq_t [FW-1:0] g, logic commitOn);
        reqGroup = g;
        do begin
            if (commitOn && randBits(1) == 1) driveCommit(randBits(2) + 1);
            if (randBits(2) == 0) backendStall = robPkg::backendStall_t'(randBits(3));
            stepCycle();
        end while (!lastAccept);
        reqGroup = '0;
    endtask

    initial begin : stimulus
        regPkg::renameReq_t [FW-1:0] g;
        for (int i = 0; i < 32; i++) refMap[i] = regPkg::preg_t'(i);
        for (int i = 32; i < PC; i++) freeQ.push_back(regPkg::preg_t'(i));
        reset = 1'b1;
        reqGroup = '0;
        backendStall = '0;
        commitGroup = '0;
        walkActive = 1'b0;
        walkGroup = '0;
        repeat (16) @(posedge clk);
        #2 reset = 1'b0;
        // slot 1 reads and slot 2 rewrites the rd of slot 0
        g = '0;
        g[0] = '{valid: 1'b1, rdValid: 1'b1, rd: 5'd1, rs1: 5'd2, rs2: 5'd3};
        g[1] = '{valid: 1'b1, rdValid: 1'b1, rd: 5'd4, rs1: 5'd1, rs2: 5'd1};
        g[2] = '{valid: 1'b1, rdValid: 1'b1, rd: 5'd1, rs1: 5'd4, rs2: 5'd7};
        g[3] = '{valid: 1'b1, rdValid: 1'b0, rd: 5'd9, rs1: 5'd1, rs2: 5'd4};
        sendGroup(g, 1'b0);
        repeat (150) sendGroup(randomGroup(1'b0), 1'b1);
        while (freeQ.size() >= FW) sendGroup(randomGroup(1'b1), 1'b0);
        reqGroup = randomGroup(1'b1);
        repeat (6) begin
            stepCycle();
            checkValue("reqReady", int'(reqReady), 0);   // no stall, only too few registers
        end
        sendGroup(reqGroup, 1'b1);
        repeat (4) begin
            driveWalk(randBits(2) + 1);
            stepCycle();
            repeat (5) sendGroup(randomGroup(1'b0), 1'b1);
        end
        repeat (4) stepCycle();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin : watchdog
        #(TestCycles * 20 + 2000);
        $display("timeout: the stimulus did not finish in time");
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/RenameUnit_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module RenameUnitAssert #(
    parameter int CommitWidth = 4,
    parameter int PregCount = 96
) (
    input wire logic clk,
    input wire logic reset,
    input wire logic [$clog2(PregCount-31)-1:0] freeCount,
    input wire logic walkActive,
    input wire logic accept,
    input wire robPkg::commitEntry_t [CommitWidth-1:0] commitGroup
);
    logic anyRelease;

    always_comb begin
        anyRelease = 1'b0;
        for (int i = 0; i < CommitWidth; i++) begin
            anyRelease = anyRelease | (commitGroup[i].valid & commitGroup[i].rdValid);
        end
    end

    countBound: assert property (@(posedge clk) disable iff (reset)
        freeCount <= (PregCount - 32)) else $error("free count above the free list depth");

    // nothing is handed out during a walk, so the count can only grow
    noAllocInWalk: assert property (@(posedge clk) disable iff (reset)
        walkActive |=> freeCount >= $past(freeCount)) else $error("free count fell during a walk");

    // the count only moves for an allocation, a release or a walk in the cycle before
    countSource: assert property (@(posedge clk) disable iff (reset)
        $changed(freeCount) |-> $past(accept || anyRelease || walkActive))
        else $error("free count changed without a cause");

endmodule

`default_nettype wire
